/* design/rt_ctx_pkg.sv */
package rt_ctx_pkg;

    localparam int num_thread = 8;
    localparam int bit_thread = 3;

    localparam logic [4:0] reg_pid = 5'd1;
    localparam logic [4:0] reg_sp = 5'd29;
    localparam logic [4:0] reg_pc = 5'd31;
    localparam logic [3:0] reg_org = 4'd14;
    localparam logic [3:0] reg_dir = 4'd15;

    localparam int fifo_depth = 4;

    typedef struct packed {
        logic [bit_thread-1:0] thread_id;
        logic [31:0] pixel_id;
        logic [31:0] pc;
        logic [31:0] sp;
    } ray_job_t;

    typedef struct packed {
        logic [127:0] shader_info;
        logic [127:0] normal;
    } hit_rec_t;

    typedef struct packed {
        logic [bit_thread-1:0] thread_id;
        logic [31:0] pixel_id;
        logic [31:0] pc;
        logic [31:0] sp;
        logic [127:0] origin;
    } ray_result_t;

    typedef struct packed {
        ray_job_t job;
        logic [127:0] origin;
        logic [127:0] direction;
        logic switched;  // set when the program yielded instead of finishing
    } ctx_return_t;

    typedef enum logic [1:0] {ld_idle, ld0, ld1, ld2} load_state_e;
    typedef enum logic [1:0] {ul_idle, ul_rd, ul_report} unload_state_e;
    typedef enum logic [1:0] {core_idle, core_run, core_finish} core_state_e;

endpackage

/* design/ray_job_dispatcher.sv */
`timescale 1ns/10ps

module ray_job_dispatcher (
    input  logic clk,
    input  logic rst_n,
    input  rt_ctx_pkg::ray_job_t job,
    input  logic job_req,
    output logic job_ack,
    output rt_ctx_pkg::ray_job_t assign_job,
    output logic assign_req,
    input  logic assign_ack,
    input  rt_ctx_pkg::ctx_return_t ret_ctx,
    input  logic ret_req,
    output logic ret_ack,
    output rt_ctx_pkg::ray_result_t result,
    output logic res_req,
    input  logic res_ack
);
    import rt_ctx_pkg::*;

    ray_job_t job_tab [num_thread];
    logic [num_thread-1:0] valid;
    logic [num_thread-1:0] ready;
    logic busy;  // a ray is somewhere between the assign and the return channel
    logic [bit_thread-1:0] sel_id;
    logic sel_found;
    logic [bit_thread-1:0] ret_id;
    logic take_job;
    logic do_assign;
    logic take_ret;

    always_comb begin
        sel_id = '0;
        sel_found = 1'b0;
        for (int i = num_thread - 1; i >= 0; i--) begin  // downward scan leaves the lowest slot
            if (ready[i]) begin
                sel_id = bit_thread'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign ret_id = ret_ctx.job.thread_id;
    assign take_job = job_req && !job_ack && !valid[job.thread_id];
    assign do_assign = !busy && !assign_req && !assign_ack && sel_found;
    // a finished ray needs a free result channel, a yielded one goes straight back to the table
    assign take_ret = ret_req && !ret_ack && (ret_ctx.switched || (!res_req && !res_ack));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job_ack <= 1'b0;
            valid <= '0;
            ready <= '0;
            busy <= 1'b0;
            assign_req <= 1'b0;
            ret_ack <= 1'b0;
            res_req <= 1'b0;
        end else begin
            if (take_job) begin
                job_ack <= 1'b1;
                valid[job.thread_id] <= 1'b1;
                ready[job.thread_id] <= 1'b1;
            end else if (!job_req) begin
                job_ack <= 1'b0;
            end
            if (do_assign) begin
                assign_req <= 1'b1;
                busy <= 1'b1;
                ready[sel_id] <= 1'b0;
            end else if (assign_req && assign_ack) begin
                assign_req <= 1'b0;
            end
            if (res_req && res_ack) begin
                res_req <= 1'b0;
            end
            if (take_ret) begin
                ret_ack <= 1'b1;
                busy <= 1'b0;
                if (ret_ctx.switched) begin
                    ready[ret_id] <= 1'b1;
                end else begin
                    valid[ret_id] <= 1'b0;  // slot is free for a new job
                    res_req <= 1'b1;
                end
            end else if (!ret_req) begin
                ret_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_job) begin
            job_tab[job.thread_id] <= job;
        end
        if (take_ret && ret_ctx.switched) begin
            job_tab[ret_id] <= ret_ctx.job;  // resume point with the advanced pc and sp
        end
        if (do_assign) begin
            assign_job <= job_tab[sel_id];
        end
        if (take_ret && !ret_ctx.switched) begin
            result <= '{thread_id: ret_ctx.job.thread_id, pixel_id: ret_ctx.job.pixel_id,
                        pc: ret_ctx.job.pc, sp: ret_ctx.job.sp, origin: ret_ctx.origin};
        end
    end

endmodule

/* design/hit_record_fifo.sv */
`timescale 1ns/10ps

module hit_record_fifo (
    input  logic clk,
    input  logic rst_n,
    input  rt_ctx_pkg::hit_rec_t wr_rec,
    input  logic hit_req,
    output logic hit_ack,
    input  logic de_q,
    output rt_ctx_pkg::hit_rec_t rd_rec,
    output logic not_empty
);
    import rt_ctx_pkg::*;

    hit_rec_t mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [$clog2(fifo_depth+1)-1:0] count;
    logic push;
    logic pop;

    assign push = hit_req && !hit_ack && (count != fifo_depth);
    assign pop = de_q && not_empty;
    assign not_empty = (count != '0);
    assign rd_rec = mem[rd_ptr];  // head entry is always visible

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                hit_ack <= 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end else if (!hit_req) begin
                hit_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

endmodule

/* design/rt_context_interface.sv */
`timescale 1ns/10ps

module rt_context_interface (
    input  logic clk,
    input  logic rst_n,
    input  rt_ctx_pkg::ray_job_t assign_job,
    input  logic assign_req,
    output logic assign_ack,
    input  rt_ctx_pkg::hit_rec_t hit,
    input  logic not_empty,
    output logic de_q,
    input  logic end_program,
    input  logic context_switch,
    input  logic [31:0] scalar_rd_data_0,
    input  logic [31:0] scalar_rd_data_1,
    input  logic [127:0] vector_rd_data_0,
    input  logic [127:0] vector_rd_data_1,
    output logic [4:0] scalar_rd_addr_0,
    output logic [4:0] scalar_rd_addr_1,
    output logic [3:0] vector_rd_addr_0,
    output logic [3:0] vector_rd_addr_1,
    output logic kernel_mode,
    output logic scalar_we,
    output logic vector_we,
    output logic [4:0] scalar_wb_addr,
    output logic [3:0] vector_wb_addr,
    output logic [31:0] scalar_wb_data,
    output logic [127:0] vector_wb_data,
    output rt_ctx_pkg::ctx_return_t ret_ctx,
    output logic ret_req,
    input  logic ret_ack
);
    import rt_ctx_pkg::*;

    load_state_e ld_state;
    load_state_e ld_next;
    unload_state_e ul_state;
    unload_state_e ul_next;
    logic upd_in;
    logic upd_out;
    logic [bit_thread-1:0] tid_q;
    logic [31:0] pid_q;
    logic [31:0] pc_q;
    logic [31:0] sp_q;
    logic [127:0] org_q;
    logic [127:0] dir_q;
    logic sw_q;

    assign scalar_rd_addr_0 = reg_pc;
    assign scalar_rd_addr_1 = reg_sp;
    assign vector_rd_addr_0 = reg_org;
    assign vector_rd_addr_1 = reg_dir;

    assign ret_ctx = '{job: '{thread_id: tid_q, pixel_id: pid_q, pc: pc_q, sp: sp_q},
                       origin: org_q, direction: dir_q, switched: sw_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_state <= ld_idle;
            ul_state <= ul_idle;
            assign_ack <= 1'b0;
        end else begin
            ld_state <= ld_next;
            ul_state <= ul_next;
            if (upd_in) begin
                assign_ack <= 1'b1;
            end else if (!assign_req) begin
                assign_ack <= 1'b0;
            end
        end
    end

    // pid and thread id survive the run, the rest is read back from the register file
    always_ff @(posedge clk) begin
        if (upd_in) begin
            tid_q <= assign_job.thread_id;
            pid_q <= assign_job.pixel_id;
            pc_q <= assign_job.pc;
            sp_q <= assign_job.sp;
            org_q <= hit.shader_info;
            dir_q <= hit.normal;
        end else if (upd_out) begin
            pc_q <= scalar_rd_data_0;
            sp_q <= scalar_rd_data_1;
            org_q <= vector_rd_data_0;
            dir_q <= vector_rd_data_1;
        end
        if (ul_state == ul_idle && end_program) begin
            sw_q <= context_switch;
        end
    end

    always_comb begin
        ld_next = ld_idle;
        upd_in = 1'b0;
        de_q = 1'b0;
        kernel_mode = 1'b0;
        scalar_we = 1'b0;
        vector_we = 1'b0;
        scalar_wb_addr = '0;
        vector_wb_addr = '0;
        scalar_wb_data = '0;
        vector_wb_data = '0;
        case (ld_state)
            ld_idle: begin
                if (assign_req && !assign_ack && not_empty) begin  // each load eats one record
                    ld_next = ld0;
                    upd_in = 1'b1;
                    de_q = 1'b1;
                end
            end
            ld0: begin
                ld_next = ld1;
                kernel_mode = 1'b1;
                scalar_we = 1'b1;
                scalar_wb_addr = reg_pid;
                scalar_wb_data = pid_q;
                vector_we = 1'b1;
                vector_wb_addr = reg_org;
                vector_wb_data = org_q;
            end
            ld1: begin
                ld_next = ld2;
                kernel_mode = 1'b1;
                scalar_we = 1'b1;
                scalar_wb_addr = reg_pc;
                scalar_wb_data = pc_q;
                vector_we = 1'b1;
                vector_wb_addr = reg_dir;
                vector_wb_data = dir_q;
            end
            default: begin
                kernel_mode = 1'b1;
                scalar_we = 1'b1;
                scalar_wb_addr = reg_sp;
                scalar_wb_data = sp_q;
            end
        endcase
    end

    always_comb begin
        ul_next = ul_state;
        upd_out = 1'b0;
        ret_req = 1'b0;
        case (ul_state)
            ul_idle: begin
                if (end_program) begin
                    ul_next = ul_rd;
                end
            end
            ul_rd: begin
                upd_out = 1'b1;
                ul_next = ul_report;
            end
            default: begin
                ret_req = 1'b1;
                if (ret_ack) begin
                    ul_next = ul_idle;
                end
            end
        endcase
    end

endmodule

/* design/rt_register_file.sv */
`timescale 1ns/10ps

module rt_register_file (
    input  logic clk,
    input  logic rst_n,
    input  logic [4:0] scalar_rd_addr_0,
    input  logic [4:0] scalar_rd_addr_1,
    input  logic [3:0] vector_rd_addr_0,
    input  logic [3:0] vector_rd_addr_1,
    output logic [31:0] scalar_rd_data_0,
    output logic [31:0] scalar_rd_data_1,
    output logic [127:0] vector_rd_data_0,
    output logic [127:0] vector_rd_data_1,
    input  logic kernel_mode,
    input  logic scalar_we,
    input  logic vector_we,
    input  logic [4:0] scalar_wb_addr,
    input  logic [3:0] vector_wb_addr,
    input  logic [31:0] scalar_wb_data,
    input  logic [127:0] vector_wb_data,
    input  logic core_scalar_we,
    input  logic [4:0] core_scalar_addr,
    input  logic [31:0] core_scalar_data,
    input  logic core_vector_we,
    input  logic [3:0] core_vector_addr,
    input  logic [127:0] core_vector_data,
    input  logic [4:0] core_rd_addr,
    output logic [31:0] core_rd_data,
    output logic [127:0] core_vrd_data
);

    logic [31:0] sregs [32];
    logic [127:0] vregs [16];
    logic s_we;
    logic v_we;
    logic [4:0] s_addr;
    logic [3:0] v_addr;
    logic [31:0] s_data;
    logic [127:0] v_data;

    // kernel mode hands both write ports to the context interface
    assign s_we = kernel_mode ? scalar_we : core_scalar_we;
    assign s_addr = kernel_mode ? scalar_wb_addr : core_scalar_addr;
    assign s_data = kernel_mode ? scalar_wb_data : core_scalar_data;
    assign v_we = kernel_mode ? vector_we : core_vector_we;
    assign v_addr = kernel_mode ? vector_wb_addr : core_vector_addr;
    assign v_data = kernel_mode ? vector_wb_data : core_vector_data;

    assign scalar_rd_data_0 = sregs[scalar_rd_addr_0];
    assign scalar_rd_data_1 = sregs[scalar_rd_addr_1];
    assign vector_rd_data_0 = vregs[vector_rd_addr_0];
    assign vector_rd_data_1 = vregs[vector_rd_addr_1];
    assign core_rd_data = sregs[core_rd_addr];
    assign core_vrd_data = vregs[core_rd_addr[3:0]];  // vector bank decodes the low four bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                sregs[i] <= '0;
            end
        end else if (s_we) begin
            sregs[s_addr] <= s_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                vregs[i] <= '0;
            end
        end else if (v_we) begin
            vregs[v_addr] <= v_data;
        end
    end

endmodule

/* design/rt_shader_core.sv */
`timescale 1ns/10ps

module rt_shader_core (
    input  logic clk,
    input  logic rst_n,
    input  logic kernel_mode,
    output logic end_program,
    output logic context_switch,
    output logic [4:0] core_rd_addr,
    input  logic [31:0] core_rd_data,
    input  logic [127:0] core_vrd_data,
    output logic core_scalar_we,
    output logic [4:0] core_scalar_addr,
    output logic [31:0] core_scalar_data,
    output logic core_vector_we,
    output logic [3:0] core_vector_addr,
    output logic [127:0] core_vector_data
);
    import rt_ctx_pkg::*;

    core_state_e state;
    logic [1:0] step;
    logic km_q;
    logic [31:0] pc_q;  // entry pc of this run
    logic [31:0] sp_q;
    logic [127:0] dir_q;
    logic pid_odd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= core_idle;
            step <= '0;
            km_q <= 1'b0;
        end else begin
            km_q <= kernel_mode;
            case (state)
                core_idle: begin
                    if (km_q && !kernel_mode) begin  // load has just finished
                        state <= core_run;
                        step <= '0;
                    end
                end
                core_run: begin
                    step <= step + 1'b1;
                    if (step == 2'd3) begin
                        state <= core_finish;
                    end
                end
                default: state <= core_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_run) begin
            case (step)
                2'd0: begin
                    pc_q <= core_rd_data;
                    dir_q <= core_vrd_data;
                end
                2'd1: sp_q <= core_rd_data;
                2'd2: pid_odd <= core_rd_data[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        core_rd_addr = reg_pc;  // low bits of the pc address also select the direction vector
        core_scalar_we = 1'b0;
        core_scalar_addr = '0;
        core_scalar_data = '0;
        core_vector_we = 1'b0;
        core_vector_addr = '0;
        core_vector_data = '0;
        end_program = (state == core_finish);
        context_switch = (state == core_finish) && pid_odd && !pc_q[4];
        if (state == core_run) begin
            case (step)
                2'd1: begin
                    core_rd_addr = reg_sp;
                    core_scalar_we = 1'b1;
                    core_scalar_addr = reg_pc;
                    core_scalar_data = pc_q + 32'd16;
                end
                2'd2: begin
                    core_rd_addr = reg_pid;
                    core_scalar_we = 1'b1;
                    core_scalar_addr = reg_sp;
                    core_scalar_data = sp_q - 32'd8;
                end
                2'd3: begin
                    core_rd_addr = {1'b0, reg_org};
                    core_vector_we = 1'b1;
                    core_vector_addr = reg_org;
                    core_vector_data = core_vrd_data ^ dir_q;
                end
                default: ;
            endcase
        end
    end

endmodule

/* design/rt_ctx_subsystem.sv */
`timescale 1ns/10ps

module rt_ctx_subsystem (
    input  logic clk,
    input  logic rst_n,
    input  rt_ctx_pkg::ray_job_t job,
    input  logic job_req,
    output logic job_ack,
    input  rt_ctx_pkg::hit_rec_t hit,
    input  logic hit_req,
    output logic hit_ack,
    output rt_ctx_pkg::ray_result_t result,
    output logic res_req,
    input  logic res_ack
);
    import rt_ctx_pkg::*;

    ray_job_t assign_job;
    logic assign_req;
    logic assign_ack;
    ctx_return_t ret_ctx;
    logic ret_req;
    logic ret_ack;
    hit_rec_t hit_head;
    logic not_empty;
    logic de_q;
    logic end_program;
    logic context_switch;
    logic [31:0] scalar_rd_data_0;
    logic [31:0] scalar_rd_data_1;
    logic [127:0] vector_rd_data_0;
    logic [127:0] vector_rd_data_1;
    logic [4:0] scalar_rd_addr_0;
    logic [4:0] scalar_rd_addr_1;
    logic [3:0] vector_rd_addr_0;
    logic [3:0] vector_rd_addr_1;
    logic kernel_mode;
    logic scalar_we;
    logic vector_we;
    logic [4:0] scalar_wb_addr;
    logic [3:0] vector_wb_addr;
    logic [31:0] scalar_wb_data;
    logic [127:0] vector_wb_data;
    logic [4:0] core_rd_addr;
    logic [31:0] core_rd_data;
    logic [127:0] core_vrd_data;
    logic core_scalar_we;
    logic [4:0] core_scalar_addr;
    logic [31:0] core_scalar_data;
    logic core_vector_we;
    logic [3:0] core_vector_addr;
    logic [127:0] core_vector_data;

    ray_job_dispatcher dispatcher_i (.*);

    hit_record_fifo fifo_i (
        .wr_rec(hit),
        .rd_rec(hit_head),
        .*
    );

    rt_context_interface ctx_if_i (
        .hit(hit_head),
        .*
    );

    rt_register_file regfile_i (.*);

    rt_shader_core core_i (.*);

endmodule

/* bench/rt_ctx_tb.sv */
`timescale 1ns/10ps

module rt_ctx_tb;
    import rt_ctx_pkg::*;

    localparam int num_entries = 8;
    localparam int cycles_per_entry = 400;

    typedef struct packed {
        logic [2:0] test_no;
        ray_job_t job;
        logic [31:0] exp_pc;
        logic [31:0] exp_sp;
    } entry_t;

    logic clk;
    logic rst_n;
    ray_job_t job;
    logic job_req;
    logic job_ack;
    hit_rec_t hit;
    logic hit_req;
    logic hit_ack;
    ray_result_t result;
    logic res_req;
    logic res_ack;

    entry_t tab [num_entries];
    entry_t exp_ent [num_thread];
    logic [127:0] exp_org [num_thread];
    logic [num_thread-1:0] expected;
    logic [num_thread-1:0] seen;
    int idx_q [$];
    hit_rec_t rec_q [$];
    logic [31:0] rng_state;
    int checks;
    int errors;
    int tests;

    rt_ctx_subsystem dut_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic hit_rec_t random_record();
        hit_rec_t r;
        for (int w = 0; w < 4; w++) begin
            r.shader_info[w*32 +: 32] = next_random();
            r.normal[w*32 +: 32] = next_random();
        end
        return r;
    endfunction

    function automatic entry_t make_entry(input int t, input int tid, input logic [31:0] pid,
                                          input logic [31:0] pc, input logic [31:0] sp,
                                          input logic [31:0] epc, input logic [31:0] esp);
        entry_t e;
        e.test_no = 3'(t);
        e.job.thread_id = bit_thread'(tid);
        e.job.pixel_id = pid;
        e.job.pc = pc;
        e.job.sp = sp;
        e.exp_pc = epc;
        e.exp_sp = esp;
        return e;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "idle after reset";
            2: return "even pixel finishes in one run";
            3: return "odd pixel yields and resumes";
            4: return "several queued jobs";
            default: return "full hit FIFO";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        checks++;
        assert (got === want) else begin
            $display("Error: %s = %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic send_job(input ray_job_t j);
        @(posedge clk);
        job <= j;
        job_req <= 1'b1;
        do begin
            @(posedge clk);
        end while (!job_ack);
        job_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (job_ack);
    endtask

    task automatic send_hit(input hit_rec_t h);
        @(posedge clk);
        hit <= h;
        hit_req <= 1'b1;
        do begin
            @(posedge clk);
        end while (!hit_ack);
        hit_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (hit_ack);
    endtask

    task automatic receive_result(output ray_result_t r);
        logic [31:0] rnd;
        do begin
            @(posedge clk);
        end while (!res_req);
        r = result;
        rnd = next_random();
        repeat (int'(rnd[17:16])) @(posedge clk);  // random hold-off before the ack
        res_ack <= 1'b1;
        do begin
            @(posedge clk);
        end while (res_req);
        res_ack <= 1'b0;
    endtask

    task automatic check_result(input ray_result_t r);
        int t;
        t = int'(r.thread_id);
        checks++;
        assert (expected[t] && !seen[t]) else begin
            $display("result for thread %0d was not expected or arrived twice", t);
            errors++;
        end
        seen[t] = 1'b1;
        check_value("result.pixel_id", 128'(r.pixel_id), 128'(exp_ent[t].job.pixel_id));
        check_value("result.pc", 128'(r.pc), 128'(exp_ent[t].exp_pc));
        check_value("result.sp", 128'(r.sp), 128'(exp_ent[t].exp_sp));
        check_value("result.origin", r.origin, exp_org[t]);
    endtask

    // builds the expected origins and the records in the order that the loads take them
    task automatic prepare_group(input int t);
        logic [num_thread-1:0] rdy;
        int runs [num_thread];
        int tid;
        hit_rec_t rec;
        idx_q.delete();
        rec_q.delete();
        expected = '0;
        seen = '0;
        rdy = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (int'(tab[i].test_no) == t) begin
                tid = int'(tab[i].job.thread_id);
                idx_q.push_back(i);
                exp_ent[tid] = tab[i];
                expected[tid] = 1'b1;
                rdy[tid] = 1'b1;
                runs[tid] = (tab[i].job.pixel_id[0] && !tab[i].job.pc[4]) ? 2 : 1;
            end
        end
        while (rdy != '0) begin
            tid = 0;
            while (!rdy[tid]) begin
                tid++;
            end
            rec = random_record();
            rec_q.push_back(rec);
            exp_org[tid] = rec.shader_info ^ rec.normal;  // the last load of a thread wins
            runs[tid]--;
            if (runs[tid] == 0) begin
                rdy[tid] = 1'b0;
            end
        end
    endtask

    task automatic check_idle();
        repeat (2) @(posedge clk);
        check_value("res_req", 128'(res_req), 128'(0));
        check_value("job_ack", 128'(job_ack), 128'(0));
        check_value("hit_ack", 128'(hit_ack), 128'(0));
    endtask

    task automatic run_group(input int t);
        prepare_group(t);
        fork
            begin
                // all jobs go in before any record so the first load is the lowest slot
                foreach (idx_q[i]) begin
                    send_job(tab[idx_q[i]].job);
                end
                foreach (rec_q[i]) begin
                    send_hit(rec_q[i]);
                end
            end
            begin
                ray_result_t r;
                repeat (idx_q.size()) begin
                    receive_result(r);
                    check_result(r);
                end
            end
        join
    endtask

    task automatic run_fifo_full(input int t);
        hit_rec_t extra;
        prepare_group(t);
        for (int i = 0; i < fifo_depth - 1; i++) begin
            rec_q.push_back(random_record());
        end
        extra = random_record();
        foreach (rec_q[i]) begin
            send_hit(rec_q[i]);
        end
        @(posedge clk);
        hit <= extra;
        hit_req <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_value("hit_ack", 128'(hit_ack), 128'(0));
        end
        fork
            begin
                send_job(tab[idx_q[0]].job);  // its load frees one FIFO entry
                do begin
                    @(posedge clk);
                end while (!hit_ack);
                hit_req <= 1'b0;
                do begin
                    @(posedge clk);
                end while (hit_ack);
            end
            begin
                ray_result_t r;
                receive_result(r);
                check_result(r);
            end
        join
    endtask

    task automatic fill_table();
        tab[0] = make_entry(2, 0, 32'h10, 32'h100, 32'h8000, 32'h110, 32'h7ff8);
        tab[1] = make_entry(3, 1, 32'h21, 32'h200, 32'h9000, 32'h220, 32'h8ff0);
        tab[2] = make_entry(4, 2, 32'h30, 32'h300, 32'ha000, 32'h310, 32'h9ff8);
        tab[3] = make_entry(4, 3, 32'h31, 32'h3e0, 32'ha800, 32'h400, 32'ha7f0);
        tab[4] = make_entry(4, 4, 32'h42, 32'h400, 32'hb000, 32'h410, 32'haff8);
        tab[5] = make_entry(4, 5, 32'h57, 32'h5a0, 32'hb800, 32'h5c0, 32'hb7f0);
        tab[6] = make_entry(4, 6, 32'h60, 32'h620, 32'hc000, 32'h630, 32'hbff8);
        tab[7] = make_entry(5, 7, 32'h70, 32'h700, 32'hf000, 32'h710, 32'heff8);
    endtask

    initial begin
        int err_before;
        clk = 1'b0;
        rst_n = 1'b0;
        job = '0;
        job_req = 1'b0;
        hit = '0;
        hit_req = 1'b0;
        res_ack = 1'b0;
        rng_state = 32'd52374;
        checks = 0;
        errors = 0;
        tests = 0;
        fill_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 1; t <= 5; t++) begin
            err_before = errors;
            if (t == 1) begin
                check_idle();
            end else if (t == 5) begin
                run_fifo_full(t);
            end else begin
                run_group(t);
            end
            tests++;
            $display("test %0d %s: %s", t, test_name(t), (errors == err_before) ? "ok" : "wrong");
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (num_entries * cycles_per_entry) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles",
                 num_entries * cycles_per_entry);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* rt_ctx.f */
design/rt_ctx_pkg.sv
design/ray_job_dispatcher.sv
design/hit_record_fifo.sv
design/rt_context_interface.sv
design/rt_register_file.sv
design/rt_shader_core.sv
design/rt_ctx_subsystem.sv
bench/rt_ctx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it once.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rt_ctx_tb \
    -f rt_ctx.f \
    -o rt_ctx_sim

sim_out=$(./obj_dir/rt_ctx_sim)
echo "$sim_out"

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
    exit 0
else
    echo "simulation reported a failure" >&2
    exit 1
fi
